// File: include/valu_macros.svh
//////////////////////////////////////////////////
// Vector ALU geometry
//////////////////////////////////////////////////

`ifndef VALU_MACROS_SVH
`define VALU_MACROS_SVH

// Datapath word and its byte enables
`define VALU_DATA_W 64
`define VALU_STRB_W 8

// Instruction queue and result queue depths
`define VALU_INSN_DEPTH 4
`define VALU_RESQ_DEPTH 2

// Instruction ids in flight, one done bit each
`define VALU_NR_IDS 8

// Vector length in elements
`define VALU_VL_W 8

// Register file address is vd followed by the word index
`define VALU_REG_W 5
`define VALU_WORD_IDX_W 4

`endif

// File: design/valu_pkg.sv
//////////////////////////////////////////////////
// Vector ALU types
//////////////////////////////////////////////////

`include "valu_macros.svh"

package valu_pkg;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Element-wise operations of the ALU
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // Element width, encoded as log2 of the size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  //////////////////////////////////////////////////
  // Identifiers and addresses
  //////////////////////////////////////////////////

  typedef logic [$clog2(`VALU_NR_IDS)-1:0] vid_t;

  // Word address in the register file
  typedef logic [`VALU_REG_W+`VALU_WORD_IDX_W-1:0] vaddr_t;

  //////////////////////////////////////////////////
  // Records
  //////////////////////////////////////////////////

  // Accepted instruction as held in the instruction queue
  typedef struct packed {
    alu_op_e                 op;
    vsew_e                   sew;
    logic [`VALU_VL_W-1:0]   vl;
    logic [`VALU_REG_W-1:0]  vd;
    vid_t                    id;
    logic                    use_scalar;
    logic [`VALU_DATA_W-1:0] scalar;
  } vinsn_t;

  // One word on its way to the register file
  // An empty byte enable marks a zero-length instruction
  typedef struct packed {
    vid_t                    id;
    vaddr_t                  addr;
    logic [`VALU_DATA_W-1:0] wdata;
    logic [`VALU_STRB_W-1:0] be;
    logic                    last;
  } result_t;

endpackage

// File: design/valu_simd_alu.sv
//////////////////////////////////////////////////
// SIMD integer ALU
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_macros.svh"

module valu_simd_alu (
  input  logic [`VALU_DATA_W-1:0] operand_a_i,
  input  logic [`VALU_DATA_W-1:0] operand_b_i,
  input  valu_pkg::alu_op_e       op_i,
  input  valu_pkg::vsew_e         sew_i,
  output logic [`VALU_DATA_W-1:0] result_o
);

  import valu_pkg::*;

  localparam int unsigned DataW = `VALU_DATA_W;
  localparam int unsigned StrbW = `VALU_STRB_W;

  // Bytes that open a new element
  logic [StrbW-1:0] elem_start;
  // Second operand, inverted for subtraction
  logic [DataW-1:0] operand_b_inv;
  logic [DataW-1:0] arith_res;
  logic             is_sub;

  always_comb begin
    unique case (sew_i)
      EW8:     elem_start = 8'hff;
      EW16:    elem_start = 8'h55;
      EW32:    elem_start = 8'h11;
      default: elem_start = 8'h01;
    endcase
  end

  // a - b is computed as a + ~b + 1
  assign is_sub        = (op_i == ALU_SUB);
  assign operand_b_inv = is_sub ? ~operand_b_i : operand_b_i;

  //////////////////////////////////////////////////
  // Byte-sliced adder
  //////////////////////////////////////////////////

  // Carry ripples byte by byte and restarts at each element boundary
  always_comb begin : p_byte_adder
    logic       carry;
    logic [8:0] byte_sum;
    carry     = 1'b0;
    byte_sum  = '0;
    arith_res = '0;
    for (int b = 0; b < StrbW; b++) begin
      // Fresh carry-in for the first byte of an element
      if (elem_start[b]) begin
        carry = is_sub;
      end
      byte_sum = {1'b0, operand_a_i[8*b +: 8]} + {1'b0, operand_b_inv[8*b +: 8]} + {8'b0, carry};
      arith_res[8*b +: 8] = byte_sum[7:0];
      carry = byte_sum[8];
    end
  end

  // Result select, logic ops do not care about element width
  always_comb begin
    unique case (op_i)
      ALU_ADD, ALU_SUB: result_o = arith_res;
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      default:          result_o = '0;
    endcase
  end

endmodule

// File: design/valu_issue.sv
//////////////////////////////////////////////////
// Vector ALU issue stage
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_macros.svh"

module valu_issue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    insn_valid_i,
  input  valu_pkg::vinsn_t        insn_i,
  output logic                    insn_ready_o,
  input  logic [`VALU_DATA_W-1:0] op0_i,
  input  logic                    op0_valid_i,
  output logic                    op0_ready_o,
  input  logic [`VALU_DATA_W-1:0] op1_i,
  input  logic                    op1_valid_i,
  output logic                    op1_ready_o,
  input  logic                    retire_i,
  input  logic                    resq_full_i,
  output logic                    push_o,
  output valu_pkg::result_t       push_entry_o
);

  import valu_pkg::*;

  localparam int unsigned DataW     = `VALU_DATA_W;
  localparam int unsigned StrbW     = `VALU_STRB_W;
  localparam int unsigned VlW       = `VALU_VL_W;
  localparam int unsigned InsnDepth = `VALU_INSN_DEPTH;
  localparam int unsigned PntW      = $clog2(InsnDepth);

  //////////////////////////////////////////////////
  // Instruction queue
  //////////////////////////////////////////////////

  vinsn_t        insn_mem_q [InsnDepth];
  // Pointers carry a wrap bit so a full queue differs from an empty one
  logic [PntW:0] accept_pnt_q;
  logic [PntW:0] issue_pnt_q;
  // Accepted and not yet retired
  logic [PntW:0] occ_cnt_q;
  logic [PntW:0] pending;
  logic          accept;
  vinsn_t        head;
  logic          head_valid;

  assign insn_ready_o = (occ_cnt_q < (PntW+1)'(InsnDepth));
  assign accept       = insn_valid_i && insn_ready_o;
  assign pending      = accept_pnt_q - issue_pnt_q;
  assign head_valid   = (pending != '0);
  assign head         = insn_mem_q[issue_pnt_q[PntW-1:0]];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_mem_q[accept_pnt_q[PntW-1:0]] <= insn_i;
    end
  end

  //////////////////////////////////////////////////
  // Element accounting
  //////////////////////////////////////////////////

  // Elements of the head already issued
  logic [VlW-1:0]               issued_cnt_q;
  logic [`VALU_WORD_IDX_W-1:0]  word_idx_q;
  logic [VlW-1:0]               remaining;
  logic [VlW-1:0]               elem_per_word;
  logic [VlW-1:0]               word_elems;
  logic [3:0]                   word_bytes;
  logic [StrbW:0]               be_wide;
  logic                         last_word;

  assign remaining     = head.vl - issued_cnt_q;
  assign elem_per_word = VlW'(StrbW >> head.sew);
  // Partial word at the tail of the vector
  assign word_elems    = (remaining < elem_per_word) ? remaining : elem_per_word;
  assign word_bytes    = 4'(word_elems << head.sew);
  // Leading ones, one per active byte
  assign be_wide       = ((StrbW+1)'(1) << word_bytes) - (StrbW+1)'(1);
  assign last_word     = (remaining == word_elems);

  //////////////////////////////////////////////////
  // Operands and handshake
  //////////////////////////////////////////////////

  logic             zero_len;
  logic             ops_ready;
  logic             issue;
  logic [DataW-1:0] scalar_rep;
  logic [DataW-1:0] alu_operand_b;
  logic [DataW-1:0] alu_result;

  // Zero-length instructions consume no operands
  assign zero_len  = (head.vl == '0);
  assign ops_ready = zero_len || (op0_valid_i && (op1_valid_i || head.use_scalar));
  assign issue     = head_valid && !resq_full_i && ops_ready;

  assign op0_ready_o = issue && !zero_len;
  assign op1_ready_o = issue && !zero_len && !head.use_scalar;

  // Scalar copied into every element of the word
  always_comb begin
    unique case (head.sew)
      EW8:     scalar_rep = {8{head.scalar[7:0]}};
      EW16:    scalar_rep = {4{head.scalar[15:0]}};
      EW32:    scalar_rep = {2{head.scalar[31:0]}};
      default: scalar_rep = head.scalar;
    endcase
  end

  assign alu_operand_b = head.use_scalar ? scalar_rep : op1_i;

  valu_simd_alu i_simd_alu (
    .operand_a_i (op0_i),
    .operand_b_i (alu_operand_b),
    .op_i        (head.op),
    .sew_i       (head.sew),
    .result_o    (alu_result)
  );

  // Result entry for the word on the operand ports
  assign push_o             = issue;
  assign push_entry_o.id    = head.id;
  assign push_entry_o.addr  = {head.vd, word_idx_q};
  assign push_entry_o.wdata = alu_result;
  assign push_entry_o.be    = be_wide[StrbW-1:0];
  assign push_entry_o.last  = last_word;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      occ_cnt_q    <= '0;
      issued_cnt_q <= '0;
      word_idx_q   <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      occ_cnt_q <= occ_cnt_q + (PntW+1)'(accept) - (PntW+1)'(retire_i);
      if (issue) begin
        if (last_word) begin
          // Move on to the next queued instruction
          issue_pnt_q  <= issue_pnt_q + 1'b1;
          issued_cnt_q <= '0;
          word_idx_q   <= '0;
        end else begin
          issued_cnt_q <= issued_cnt_q + word_elems;
          word_idx_q   <= word_idx_q + 1'b1;
        end
      end
    end
  end

endmodule

// File: design/valu_result_queue.sv
//////////////////////////////////////////////////
// Vector ALU result queue
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_macros.svh"

module valu_result_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  valu_pkg::result_t push_entry_i,
  output logic              full_o,
  input  logic              pop_i,
  output logic              head_valid_o,
  output valu_pkg::result_t head_entry_o
);

  import valu_pkg::*;

  localparam int unsigned Depth = `VALU_RESQ_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  //////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////

  result_t       mem_q [Depth];
  logic [PntW-1:0] wr_pnt_q;
  logic [PntW-1:0] rd_pnt_q;
  // Entries currently held
  logic [PntW:0]   cnt_q;
  logic            do_push;
  logic            do_pop;

  assign full_o       = (cnt_q == (PntW+1)'(Depth));
  assign head_valid_o = (cnt_q != '0);
  assign head_entry_o = mem_q[rd_pnt_q];

  // Writes into a full ring are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_pnt_q] <= push_entry_i;
    end
  end

  //////////////////////////////////////////////////
  // Pointer and count update
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        // Wrap at the ring end
        if (wr_pnt_q == PntW'(Depth - 1)) begin
          wr_pnt_q <= '0;
        end else begin
          wr_pnt_q <= wr_pnt_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_pnt_q == PntW'(Depth - 1)) begin
          rd_pnt_q <= '0;
        end else begin
          rd_pnt_q <= rd_pnt_q + 1'b1;
        end
      end
      // Push and pop together leave the count unchanged
      cnt_q <= cnt_q + (PntW+1)'(do_push) - (PntW+1)'(do_pop);
    end
  end

endmodule

// File: design/valu_commit.sv
//////////////////////////////////////////////////
// Vector ALU commit stage
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_macros.svh"

module valu_commit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    head_valid_i,
  input  valu_pkg::result_t       head_entry_i,
  output logic                    pop_o,
  output logic                    result_req_o,
  output valu_pkg::vid_t          result_id_o,
  output valu_pkg::vaddr_t        result_addr_o,
  output logic [`VALU_DATA_W-1:0] result_wdata_o,
  output logic [`VALU_STRB_W-1:0] result_be_o,
  input  logic                    result_gnt_i,
  output logic [`VALU_NR_IDS-1:0] vinsn_done_o,
  output logic                    retire_o
);

  import valu_pkg::*;

  // Request register, held until granted
  logic   req_q;
  result_t out_q;
  logic   gnt_fire;
  logic   load;
  // Empty entry of a zero-length instruction
  logic   zero_pop;
  logic [`VALU_NR_IDS-1:0] done_q;
  logic   retire_q;

  assign gnt_fire = req_q && result_gnt_i;
  assign load     = head_valid_i && (head_entry_i.be != '0) && (!req_q || result_gnt_i);
  // Only with the register idle, so done pulses keep acceptance order
  assign zero_pop = head_valid_i && (head_entry_i.be == '0) && !req_q;
  assign pop_o    = load || zero_pop;

  assign result_req_o   = req_q;
  assign result_id_o    = out_q.id;
  assign result_addr_o  = out_q.addr;
  assign result_wdata_o = out_q.wdata;
  assign result_be_o    = out_q.be;
  assign vinsn_done_o   = done_q;
  assign retire_o       = retire_q;

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_q <= head_entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= 1'b0;
      done_q   <= '0;
      retire_q <= 1'b0;
    end else begin
      if (load) begin
        req_q <= 1'b1;
      end else if (gnt_fire) begin
        req_q <= 1'b0;
      end
      // One-cycle done and retire for the finishing instruction
      done_q   <= '0;
      retire_q <= 1'b0;
      if (gnt_fire && out_q.last) begin
        done_q[out_q.id] <= 1'b1;
        retire_q         <= 1'b1;
      end else if (zero_pop) begin
        done_q[head_entry_i.id] <= 1'b1;
        retire_q                <= 1'b1;
      end
    end
  end

endmodule

// File: design/valu_top.sv
//////////////////////////////////////////////////
// Vector ALU top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_macros.svh"

module valu_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Instruction strobe and fields
  input  logic                    insn_valid_i,
  input  valu_pkg::alu_op_e       insn_op_i,
  input  valu_pkg::vsew_e         insn_sew_i,
  input  logic [`VALU_VL_W-1:0]   insn_vl_i,
  input  logic [`VALU_REG_W-1:0]  insn_vd_i,
  input  valu_pkg::vid_t          insn_id_i,
  input  logic                    insn_use_scalar_i,
  input  logic [`VALU_DATA_W-1:0] insn_scalar_i,
  output logic                    insn_ready_o,
  // Operand streams
  input  logic [`VALU_DATA_W-1:0] op0_i,
  input  logic                    op0_valid_i,
  output logic                    op0_ready_o,
  input  logic [`VALU_DATA_W-1:0] op1_i,
  input  logic                    op1_valid_i,
  output logic                    op1_ready_o,
  // Register file write port
  output logic                    result_req_o,
  output valu_pkg::vid_t          result_id_o,
  output valu_pkg::vaddr_t        result_addr_o,
  output logic [`VALU_DATA_W-1:0] result_wdata_o,
  output logic [`VALU_STRB_W-1:0] result_be_o,
  input  logic                    result_gnt_i,
  output logic [`VALU_NR_IDS-1:0] vinsn_done_o
);

  import valu_pkg::*;

  vinsn_t  insn;
  logic    retire;
  logic    resq_full;
  logic    push;
  result_t push_entry;
  logic    pop;
  logic    head_valid;
  result_t head_entry;

  // Gather the loose instruction fields
  assign insn = '{op: insn_op_i, sew: insn_sew_i, vl: insn_vl_i, vd: insn_vd_i,
                  id: insn_id_i, use_scalar: insn_use_scalar_i, scalar: insn_scalar_i};

  valu_issue i_issue (
    .clk_i, .rst_ni, .insn_valid_i, .insn_i (insn), .insn_ready_o,
    .op0_i, .op0_valid_i, .op0_ready_o, .op1_i, .op1_valid_i, .op1_ready_o,
    .retire_i (retire), .resq_full_i (resq_full), .push_o (push), .push_entry_o (push_entry)
  );

  valu_result_queue i_result_queue (
    .clk_i, .rst_ni, .push_i (push), .push_entry_i (push_entry), .full_o (resq_full),
    .pop_i (pop), .head_valid_o (head_valid), .head_entry_o (head_entry)
  );

  valu_commit i_commit (
    .clk_i, .rst_ni, .head_valid_i (head_valid), .head_entry_i (head_entry), .pop_o (pop),
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i, .vinsn_done_o, .retire_o (retire)
  );

endmodule

// File: tb/valu_assertions.sv
//////////////////////////////////////////////////
// Vector ALU protocol checks
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_macros.svh"

module valu_assertions (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    req_i,
  input logic                    gnt_i,
  input valu_pkg::vid_t          id_i,
  input valu_pkg::vaddr_t        addr_i,
  input logic [`VALU_DATA_W-1:0] wdata_i,
  input logic [`VALU_STRB_W-1:0] be_i,
  input logic [`VALU_NR_IDS-1:0] done_i,
  input logic                    op0_ready_i,
  input logic                    op1_ready_i
);

  // Failed assertions so far
  int fail_cnt = 0;

  // Pending request and its fields hold until granted
  property p_req_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      (req_i && !gnt_i) |=> (req_i && $stable(id_i) && $stable(addr_i) &&
                             $stable(wdata_i) && $stable(be_i));
  endproperty

  a_req_stable: assert property (p_req_stable)
    else begin
      $error("register file request changed before its grant");
      fail_cnt++;
    end

  // At most one instruction finishes per cycle
  a_done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(done_i))
    else begin
      $error("done vector has more than one bit set");
      fail_cnt++;
    end

  // Quiet outputs while in reset
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (!req_i && !op0_ready_i && !op1_ready_i))
    else begin
      $error("request or operand ready active during reset");
      fail_cnt++;
    end

endmodule

// File: tb/valu_tb.sv
//////////////////////////////////////////////////
// Vector ALU testbench
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_macros.svh"

module valu_tb;

  import valu_pkg::*;

  localparam int DataW       = `VALU_DATA_W;
  localparam int ResetCycles = 10;
  // Budgets of tests 1 to 6 are 60, 120, 100, 60, 160 and 100 cycles, plus a margin
  localparam int CycleLimit  = ResetCycles + 600 + 200;

  // One expected register file write
  typedef struct packed {
    vid_t                    id;
    vaddr_t                  addr;
    logic [DataW-1:0]        wdata;
    logic [`VALU_STRB_W-1:0] be;
  } write_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    insn_valid_i;
  alu_op_e                 insn_op_i;
  vsew_e                   insn_sew_i;
  logic [`VALU_VL_W-1:0]   insn_vl_i;
  logic [`VALU_REG_W-1:0]  insn_vd_i;
  vid_t                    insn_id_i;
  logic                    insn_use_scalar_i;
  logic [DataW-1:0]        insn_scalar_i;
  logic                    insn_ready_o;
  logic [DataW-1:0]        op0_i;
  logic                    op0_valid_i;
  logic                    op0_ready_o;
  logic [DataW-1:0]        op1_i;
  logic                    op1_valid_i;
  logic                    op1_ready_o;
  logic                    result_req_o;
  vid_t                    result_id_o;
  vaddr_t                  result_addr_o;
  logic [DataW-1:0]        result_wdata_o;
  logic [`VALU_STRB_W-1:0] result_be_o;
  logic                    result_gnt_i;
  logic [`VALU_NR_IDS-1:0] vinsn_done_o;

  // Reference model state
  write_t           exp_wr_q [$];
  vid_t             exp_done_q [$];
  logic [DataW-1:0] op0_q [$];
  logic [DataW-1:0] op1_q [$];
  write_t           exp_wr;
  logic             exp_wr_valid;
  vid_t             exp_done;
  logic             exp_done_valid;
  int               outstanding;
  int               err_cnt = 0;
  int               err_mark = 0;
  int               test_num = 0;
  int               cycle_cnt;
  logic             stall_grant;
  logic             force_msb;
  logic             scalar_phase;

  valu_top dut0 (.*);

  bind valu_top valu_assertions u_assert (
    .clk_i, .rst_ni, .req_i (result_req_o), .gnt_i (result_gnt_i), .id_i (result_id_o),
    .addr_i (result_addr_o), .wdata_i (result_wdata_o), .be_i (result_be_o),
    .done_i (vinsn_done_o), .op0_ready_i (op0_ready_o), .op1_ready_i (op1_ready_o)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Scalar copied into each element
  function automatic logic [DataW-1:0] replicate(logic [DataW-1:0] sc, vsew_e sew);
    int unsigned      ew;
    logic [DataW-1:0] mask;
    logic [DataW-1:0] res;
    ew   = 8 << sew;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    res  = '0;
    for (int e = 0; e < 64 / ew; e++) begin
      res = res | ((sc & mask) << (e * ew));
    end
    return res;
  endfunction

  // Each element on its own with the result cut to the element width
  function automatic logic [DataW-1:0] expect_word(alu_op_e op, vsew_e sew,
                                                   logic [DataW-1:0] a, logic [DataW-1:0] b);
    int unsigned      ew;
    logic [DataW-1:0] mask;
    logic [DataW-1:0] ea;
    logic [DataW-1:0] eb;
    logic [DataW-1:0] er;
    logic [DataW-1:0] res;
    ew   = 8 << sew;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    res  = '0;
    for (int e = 0; e < 64 / ew; e++) begin
      ea = (a >> (e * ew)) & mask;
      eb = (b >> (e * ew)) & mask;
      case (op)
        ALU_ADD: er = ea + eb;
        ALU_SUB: er = ea - eb;
        ALU_AND: er = ea & eb;
        ALU_OR:  er = ea | eb;
        default: er = ea ^ eb;
      endcase
      res = res | ((er & mask) << (e * ew));
    end
    return res;
  endfunction

  task automatic refresh_head();
    exp_wr_valid   = (exp_wr_q.size() != 0);
    exp_done_valid = (exp_done_q.size() != 0);
    if (exp_wr_valid) begin
      exp_wr = exp_wr_q[0];
    end
    if (exp_done_valid) begin
      exp_done = exp_done_q[0];
    end
  endtask

  function automatic int total_errors();
    return err_cnt + dut0.u_assert.fail_cnt;
  endfunction

  // Retire expected entries as the DUT writes and finishes
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding <= 0;
    end else begin
      if (result_req_o && result_gnt_i && exp_wr_q.size() != 0) begin
        void'(exp_wr_q.pop_front());
      end
      if (vinsn_done_o != '0 && exp_done_q.size() != 0) begin
        void'(exp_done_q.pop_front());
      end
      outstanding <= outstanding + int'(insn_valid_i && insn_ready_o) - int'(vinsn_done_o != '0);
      refresh_head();
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_write_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && result_gnt_i) |-> exp_wr_valid)
    else begin
      $display("Register file write at %0t when no write was expected", $time);
      err_cnt++;
    end

  a_write_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && result_gnt_i && exp_wr_valid) |->
      (result_id_o == exp_wr.id && result_addr_o == exp_wr.addr &&
       result_wdata_o == exp_wr.wdata && result_be_o == exp_wr.be))
    else begin
      $display("[FAIL] %0t: write id %0d addr %0h data %0h be %0h, expected %0d %0h %0h %0h",
               $time, result_id_o, result_addr_o, result_wdata_o, result_be_o,
               exp_wr.id, exp_wr.addr, exp_wr.wdata, exp_wr.be);
      err_cnt++;
    end

  // Done pulses follow acceptance order
  a_done_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (vinsn_done_o != '0) |->
      (exp_done_valid && vinsn_done_o == (`VALU_NR_IDS'(1) << exp_done)))
    else begin
      $display("[FAIL] %0t: done pulse %0h, expected id %0d", $time, vinsn_done_o, exp_done);
      err_cnt++;
    end

  a_insn_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    insn_ready_o == (outstanding < `VALU_INSN_DEPTH))
    else begin
      $display("[FAIL] %0t: insn_ready_o is %0b with %0d outstanding", $time,
               insn_ready_o, outstanding);
      err_cnt++;
    end

  a_no_op1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scalar_phase |-> !op1_ready_o)
    else begin
      $display("Operand 1 was acknowledged at %0t for a scalar instruction", $time);
      err_cnt++;
    end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Queue operands and expected writes, then offer the instruction
  task automatic send_insn(alu_op_e op, vsew_e sew, int vl, int vd, int id,
                           logic use_sc, logic [DataW-1:0] sc);
    int               epw;
    int               rem;
    int               n;
    int               widx;
    logic [DataW-1:0] a;
    logic [DataW-1:0] b;
    write_t           w;
    epw  = 8 >> sew;
    rem  = vl;
    widx = 0;
    while (rem > 0) begin
      n = (rem < epw) ? rem : epw;
      a = {$urandom, $urandom};
      b = use_sc ? replicate(sc, sew) : {$urandom, $urandom};
      // High bits set so sums and differences overflow
      if (force_msb && !use_sc) begin
        a = a | 64'h8080_8080_8080_8080;
        b = b | 64'h8080_8080_8080_8080;
      end
      op0_q.push_back(a);
      if (!use_sc) begin
        op1_q.push_back(b);
      end
      w.id    = vid_t'(id);
      w.addr  = {`VALU_REG_W'(vd), `VALU_WORD_IDX_W'(widx)};
      w.wdata = expect_word(op, sew, a, b);
      w.be    = '0;
      for (int k = 0; k < (n << sew); k++) begin
        w.be[k] = 1'b1;
      end
      exp_wr_q.push_back(w);
      rem  = rem - n;
      widx = widx + 1;
    end
    exp_done_q.push_back(vid_t'(id));
    refresh_head();
    insn_valid_i      = 1'b1;
    insn_op_i         = op;
    insn_sew_i        = sew;
    insn_vl_i         = `VALU_VL_W'(vl);
    insn_vd_i         = `VALU_REG_W'(vd);
    insn_id_i         = vid_t'(id);
    insn_use_scalar_i = use_sc;
    insn_scalar_i     = sc;
    do begin
      @(posedge clk_i);
    end while (!insn_ready_o);
    #1;
    insn_valid_i = 1'b0;
  endtask

  task automatic drive_operands();
    forever begin
      @(posedge clk_i);
      if (op0_valid_i && op0_ready_o) begin
        void'(op0_q.pop_front());
      end
      if (op1_valid_i && op1_ready_o) begin
        void'(op1_q.pop_front());
      end
      #1;
      op0_valid_i = (op0_q.size() != 0);
      op1_valid_i = (op1_q.size() != 0);
      op0_i       = op0_valid_i ? op0_q[0] : '0;
      op1_i       = op1_valid_i ? op1_q[0] : '0;
    end
  endtask

  // Random stalls on the grant, or none at all while held
  task automatic drive_grant();
    forever begin
      @(posedge clk_i);
      #1;
      result_gnt_i = !stall_grant && ($urandom_range(3) != 0);
    end
  endtask

  task automatic finish_test(string name);
    int fails;
    while (exp_done_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    // Every write of the test lands before its done pulse
    if (exp_wr_q.size() != 0) begin
      $display("%0d expected register file writes never arrived by %0t",
               exp_wr_q.size(), $time);
      err_cnt++;
      exp_wr_q.delete();
      refresh_head();
    end
    fails    = total_errors() - err_mark;
    err_mark = total_errors();
    test_num++;
    $display("Test %0d (%s) finished with %0d failed checks", test_num, name, fails);
    #1;
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(96));
    rst_ni            = 1'b0;
    insn_valid_i      = 1'b0;
    insn_op_i         = ALU_ADD;
    insn_sew_i        = EW8;
    insn_vl_i         = '0;
    insn_vd_i         = '0;
    insn_id_i         = '0;
    insn_use_scalar_i = 1'b0;
    insn_scalar_i     = '0;
    op0_i             = '0;
    op0_valid_i       = 1'b0;
    op1_i             = '0;
    op1_valid_i       = 1'b0;
    result_gnt_i      = 1'b0;
    stall_grant       = 1'b0;
    force_msb         = 1'b0;
    scalar_phase      = 1'b0;
    refresh_head();
    fork
      drive_operands();
      drive_grant();
    join_none
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    send_insn(ALU_ADD, EW64, 3, 2, 1, 1'b0, '0);
    finish_test("add at 64-bit elements");

    // Element wrap at 8 and 16 bits
    force_msb = 1'b1;
    send_insn(ALU_SUB, EW8, 16, 3, 2, 1'b0, '0);
    send_insn(ALU_AND, EW8, 8, 4, 2, 1'b0, '0);
    send_insn(ALU_OR, EW16, 4, 5, 3, 1'b0, '0);
    send_insn(ALU_XOR, EW16, 8, 6, 3, 1'b0, '0);
    send_insn(ALU_ADD, EW8, 8, 7, 4, 1'b0, '0);
    send_insn(ALU_SUB, EW16, 8, 8, 4, 1'b0, '0);
    send_insn(ALU_AND, EW16, 4, 26, 5, 1'b0, '0);
    send_insn(ALU_OR, EW8, 8, 27, 5, 1'b0, '0);
    send_insn(ALU_XOR, EW8, 8, 28, 6, 1'b0, '0);
    force_msb = 1'b0;
    finish_test("overflow at narrow elements");

    scalar_phase = 1'b1;
    send_insn(ALU_ADD, EW8, 16, 9, 5, 1'b1, 64'hdead_beef_0123_45f7);
    send_insn(ALU_SUB, EW16, 8, 10, 5, 1'b1, 64'h1111_2222_3333_fff0);
    send_insn(ALU_XOR, EW32, 4, 11, 6, 1'b1, 64'hcafe_f00d_8765_4321);
    send_insn(ALU_OR, EW64, 2, 12, 6, 1'b1, 64'h0f0f_0000_ffff_1234);
    finish_test("scalar operand");
    scalar_phase = 1'b0;

    // Partial tail word and an empty vector
    send_insn(ALU_ADD, EW16, 5, 13, 7, 1'b0, '0);
    send_insn(ALU_XOR, EW8, 0, 14, 0, 1'b0, '0);
    send_insn(ALU_SUB, EW32, 3, 15, 1, 1'b0, '0);
    finish_test("partial and empty vectors");

    stall_grant = 1'b1;
    fork
      begin
        for (int i = 0; i < 5; i++) begin
          send_insn(ALU_ADD, EW32, 4, 16 + i, i, 1'b0, '0);
        end
      end
      begin
        // Long stall, a short burst of grants, then a second stall
        repeat (40) @(posedge clk_i);
        stall_grant = 1'b0;
        repeat (6) @(posedge clk_i);
        stall_grant = 1'b1;
        repeat (20) @(posedge clk_i);
        stall_grant = 1'b0;
      end
    join
    finish_test("grant back-pressure");

    send_insn(ALU_ADD, EW8, 12, 21, 3, 1'b0, '0);
    send_insn(ALU_XOR, EW64, 1, 22, 5, 1'b0, '0);
    send_insn(ALU_SUB, EW16, 0, 23, 6, 1'b0, '0);
    send_insn(ALU_AND, EW32, 7, 24, 7, 1'b1, 64'h0000_00ff_f0f0_3c3c);
    send_insn(ALU_OR, EW8, 3, 25, 0, 1'b0, '0);
    finish_test("done order over queued ids");

    $display("Tests run: %0d, failed checks: %0d", test_num, total_errors());
    if (total_errors() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+include
design/valu_pkg.sv
design/valu_simd_alu.sv
design/valu_issue.sv
design/valu_result_queue.sv
design/valu_commit.sv
design/valu_top.sv
tb/valu_assertions.sv
tb/valu_tb.sv
